// File: design/streamer_cfg_pkg.sv
`default_nettype none

package streamer_cfg_pkg;

  // Scratchpad word address width
  localparam int unsigned MemAddrW = 10;

  // Memory data word width
  localparam int unsigned DataW = 32;

  // Element count width
  localparam int unsigned LenW = 8;

  // Arbiter clients, three loads and one store
  localparam int unsigned NumChan = 4;

  // Channel indices on the arbiter
  localparam int unsigned XId = 0;
  localparam int unsigned WId = 1;
  localparam int unsigned YId = 2;
  localparam int unsigned ZId = 3;

  typedef logic [MemAddrW-1:0] addr_t;
  typedef logic [DataW-1:0]    word_t;
  typedef logic [LenW-1:0]     len_t;

endpackage

`default_nettype wire

// File: design/streamer_ctrl_pkg.sv
`default_nettype none

package streamer_ctrl_pkg;

  // Element format in memory
  // FP16 sits in the low half of a word
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } cast_fmt_e;

  // Channel FSM states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    WAIT = 2'd2,
    PUSH = 2'd3
  } chan_state_e;

endpackage

`default_nettype wire

// File: design/mem_arbiter.sv
`default_nettype none

module mem_arbiter
  import streamer_cfg_pkg::*;
#(
  parameter int unsigned AddrW = MemAddrW
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [NumChan-1:0]            req_i,
  input  logic [NumChan-1:0][AddrW-1:0] addr_i,
  input  logic [NumChan-1:0]            we_i,
  input  word_t [NumChan-1:0]           wdata_i,
  output logic [NumChan-1:0]            gnt_o,
  output logic                          mem_en_o,
  output logic                          mem_we_o,
  output logic [AddrW-1:0]              mem_addr_o,
  output word_t                         mem_wdata_o
);

  localparam int unsigned IdxW = $clog2(NumChan);

  // Last granted channel
  logic [IdxW-1:0] last_q;
  // Winner of this cycle
  logic [IdxW-1:0] sel;
  logic            any_req;

  assign any_req = |req_i;

  // Search starts one past the last grant
  // Descending loop so the nearest requester wins
  always_comb begin
    sel = last_q;
    for (int unsigned k = NumChan; k >= 1; k--) begin
      int unsigned cand;
      cand = (int'(last_q) + k) % NumChan;
      if (req_i[cand]) begin
        sel = IdxW'(cand);
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (any_req) begin
      gnt_o[sel] = 1'b1;
    end
  end

  // Granted channel drives the memory
  assign mem_en_o    = any_req;
  assign mem_we_o    = any_req & we_i[sel];
  assign mem_addr_o  = addr_i[sel];
  assign mem_wdata_o = wdata_i[sel];

  // Channel 0 gets the first grant after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q <= IdxW'(NumChan - 1);
    end else if (any_req) begin
      last_q <= sel;
    end
  end

  // At most one grant per cycle and only to a requester
  a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0));

endmodule

`default_nettype wire

// File: design/scratch_mem.sv
`default_nettype none

module scratch_mem
  import streamer_cfg_pkg::*;
#(
  parameter int unsigned AddrW = MemAddrW
) (
  input  logic             clk_i,
  input  logic             en_i,
  input  logic             we_i,
  input  logic [AddrW-1:0] addr_i,
  input  word_t            wdata_i,
  output word_t            rdata_o
);

  localparam int unsigned Depth = 2 ** AddrW;

  // Word array
  word_t mem_q [Depth];

  // Registered read port
  word_t rdata_q;

  // Single port, one access per cycle
  // Read data shows up the cycle after the access
  // Held between reads
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/load_channel.sv
`default_nettype none

module load_channel
  import streamer_cfg_pkg::*;
  import streamer_ctrl_pkg::*;
#(
  parameter int unsigned AddrW = MemAddrW
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             start_i,
  input  logic [AddrW-1:0] base_i,
  input  logic [AddrW-1:0] stride_i,
  input  len_t             len_i,
  input  cast_fmt_e        fmt_i,
  input  logic             gnt_i,
  input  logic             rvalid_i,
  input  word_t            rdata_i,
  input  logic             ready_i,
  output logic             req_o,
  output logic [AddrW-1:0] addr_o,
  output word_t            data_o,
  output logic             valid_o
);

  // FP16 to FP32 field move without rounding
  // Exponent rebias 15 to 127
  function automatic word_t cast_in(input word_t raw, input cast_fmt_e fmt);
    word_t      res;
    logic [7:0] exp32;
    res   = raw;
    exp32 = {3'b000, raw[14:10]} + 8'd112;
    if (fmt == FMT_FP16) begin
      if (raw[14:0] == '0) begin
        // Signed zero only keeps the sign
        res = {raw[15], 31'b0};
      end else begin
        res = {raw[15], exp32, raw[9:0], 13'b0};
      end
    end
    return res;
  endfunction

  chan_state_e      state_q;
  logic [AddrW-1:0] addr_q;
  logic [AddrW-1:0] stride_q;
  // Elements still to push
  len_t             cnt_q;
  cast_fmt_e        fmt_q;
  // Casted word waiting on the stream
  word_t            data_q;

  // IDLE -> REQ -> WAIT -> PUSH and back to REQ per element
  // One read in flight at most
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      addr_q   <= '0;
      stride_q <= '0;
      cnt_q    <= '0;
      fmt_q    <= FMT_FP32;
    end else begin
      case (state_q)
        IDLE: begin
          // Zero length job never leaves idle
          if (start_i && (len_i != '0)) begin
            addr_q   <= base_i;
            stride_q <= stride_i;
            cnt_q    <= len_i;
            fmt_q    <= fmt_i;
            state_q  <= REQ;
          end
        end
        REQ: begin
          // Address held until granted
          if (gnt_i) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          if (rvalid_i) begin
            state_q <= PUSH;
          end
        end
        PUSH: begin
          // Handshake done so step to the next element
          if (ready_i) begin
            addr_q  <= addr_q + stride_q;
            cnt_q   <= cnt_q - 1'b1;
            state_q <= (cnt_q == len_t'(1)) ? IDLE : REQ;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Cast on the way in from memory
  always_ff @(posedge clk_i) begin
    if ((state_q == WAIT) && rvalid_i) begin
      data_q <= cast_in(rdata_i, fmt_q);
    end
  end

  assign req_o   = (state_q == REQ);
  assign addr_o  = addr_q;
  assign valid_o = (state_q == PUSH);
  assign data_o  = data_q;

  // Stalled stream holds off the next read
  a_no_req_stalled : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> !req_o);

endmodule

`default_nettype wire

// File: design/store_channel.sv
`default_nettype none

module store_channel
  import streamer_cfg_pkg::*;
  import streamer_ctrl_pkg::*;
#(
  parameter int unsigned AddrW = MemAddrW
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             start_i,
  input  logic [AddrW-1:0] base_i,
  input  logic [AddrW-1:0] stride_i,
  input  len_t             len_i,
  input  cast_fmt_e        fmt_i,
  input  word_t            data_i,
  input  logic             valid_i,
  input  logic             gnt_i,
  output logic             ready_o,
  output logic             req_o,
  output logic [AddrW-1:0] addr_o,
  output word_t            wdata_o,
  output logic             done_o
);

  // FP32 to FP16 field move, result zero-extended
  function automatic word_t cast_out(input word_t raw, input cast_fmt_e fmt);
    word_t      res;
    logic [7:0] exp16;
    res   = raw;
    exp16 = raw[30:23] - 8'd112;
    if (fmt == FMT_FP16) begin
      if (raw[30:0] == '0) begin
        res = {16'b0, raw[31], 15'b0};
      end else begin
        res = {16'b0, raw[31], exp16[4:0], raw[22:13]};
      end
    end
    return res;
  endfunction

  // PUSH waits for a word, REQ waits for the write grant
  chan_state_e      state_q;
  logic [AddrW-1:0] addr_q;
  logic [AddrW-1:0] stride_q;
  len_t             cnt_q;
  cast_fmt_e        fmt_q;
  logic             done_q;
  word_t            wdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      addr_q   <= '0;
      stride_q <= '0;
      cnt_q    <= '0;
      fmt_q    <= FMT_FP32;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            addr_q   <= base_i;
            stride_q <= stride_i;
            cnt_q    <= len_i;
            fmt_q    <= fmt_i;
            // Empty job finishes right away
            if (len_i == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= PUSH;
            end
          end
        end
        PUSH: begin
          if (valid_i) begin
            state_q <= REQ;
          end
        end
        REQ: begin
          if (gnt_i) begin
            addr_q <= addr_q + stride_q;
            cnt_q  <= cnt_q - 1'b1;
            // Last write granted
            if (cnt_q == len_t'(1)) begin
              done_q  <= 1'b1;
              state_q <= IDLE;
            end else begin
              state_q <= PUSH;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Accepted word, narrowed before the write
  always_ff @(posedge clk_i) begin
    if ((state_q == PUSH) && valid_i) begin
      wdata_q <= cast_out(data_i, fmt_q);
    end
  end

  assign ready_o = (state_q == PUSH);
  assign req_o   = (state_q == REQ);
  assign addr_o  = addr_q;
  assign wdata_o = wdata_q;
  assign done_o  = done_q;

  // Write request stays put until the arbiter takes it
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_o && !gnt_i) |=> (req_o && $stable(addr_o) && $stable(wdata_o)));

endmodule

`default_nettype wire

// File: design/mac_engine.sv
`default_nettype none

module mac_engine
  import streamer_cfg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  word_t x_i,
  input  logic  x_valid_i,
  input  word_t w_i,
  input  logic  w_valid_i,
  input  word_t y_i,
  input  logic  y_valid_i,
  input  logic  z_ready_i,
  output logic  x_ready_o,
  output logic  w_ready_o,
  output logic  y_ready_o,
  output word_t z_o,
  output logic  z_valid_o
);

  // Output slot
  word_t z_q;
  logic  z_valid_q;
  // All operands present
  logic  ops_valid;
  // Slot free or draining this cycle
  logic  slot_free;
  logic  fire;

  assign ops_valid = x_valid_i & w_valid_i & y_valid_i;
  assign slot_free = ~z_valid_q | z_ready_i;
  assign fire      = ops_valid & slot_free;

  // Operands taken together or not at all
  assign x_ready_o = fire;
  assign w_ready_o = fire;
  assign y_ready_o = fire;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      z_valid_q <= 1'b0;
    end else if (fire) begin
      z_valid_q <= 1'b1;
    end else if (z_ready_i) begin
      z_valid_q <= 1'b0;
    end
  end

  // Integer multiply-add on raw bits, kept to 32 bits
  always_ff @(posedge clk_i) begin
    if (fire) begin
      z_q <= x_i * w_i + y_i;
    end
  end

  assign z_o       = z_q;
  assign z_valid_o = z_valid_q;

endmodule

`default_nettype wire

// File: design/streamer_top.sv
`default_nettype none

module streamer_top
  import streamer_cfg_pkg::*;
  import streamer_ctrl_pkg::*;
#(
  parameter int unsigned AddrW = $bits(addr_t)
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      start_i,
  input  addr_t     x_base_i,
  input  addr_t     x_stride_i,
  input  addr_t     w_base_i,
  input  addr_t     w_stride_i,
  input  addr_t     y_base_i,
  input  addr_t     y_stride_i,
  input  addr_t     z_base_i,
  input  addr_t     z_stride_i,
  input  len_t      len_i,
  input  cast_fmt_e fmt_in_i,
  input  cast_fmt_e fmt_out_i,
  input  logic      host_we_i,
  input  addr_t     host_addr_i,
  input  word_t     host_wdata_i,
  output word_t     host_rdata_o,
  output logic      busy_o,
  output logic      done_o
);

  logic                          busy_q;
  logic                          job_start;
  // Arbiter side, one slot per channel
  logic [NumChan-1:0]            ch_req;
  logic [NumChan-1:0]            ch_gnt;
  logic [NumChan-1:0][AddrW-1:0] ch_addr;
  logic [NumChan-1:0]            ch_we;
  word_t [NumChan-1:0]           ch_wdata;
  // Per-load config and streams
  logic [YId:XId][AddrW-1:0]     ld_base;
  logic [YId:XId][AddrW-1:0]     ld_stride;
  word_t [YId:XId]               ld_data;
  logic [YId:XId]                ld_valid;
  logic [YId:XId]                ld_ready;
  logic [YId:XId]                rvalid_q;
  // Engine to store
  word_t                         z_data;
  logic                          z_valid;
  logic                          z_ready;
  logic                          st_done;
  // Memory port, before and after the host mux
  logic                          arb_en;
  logic                          arb_we;
  logic [AddrW-1:0]              arb_addr;
  word_t                         arb_wdata;
  logic                          mem_en;
  logic                          mem_we;
  logic [AddrW-1:0]              mem_addr;
  word_t                         mem_wdata;
  word_t                         mem_rdata;

  // Start ignored mid-job
  assign job_start = start_i & ~busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (job_start) begin
      busy_q <= 1'b1;
    end else if (st_done) begin
      busy_q <= 1'b0;
    end
  end

  assign ld_base[XId]   = x_base_i;
  assign ld_base[WId]   = w_base_i;
  assign ld_base[YId]   = y_base_i;
  assign ld_stride[XId] = x_stride_i;
  assign ld_stride[WId] = w_stride_i;
  assign ld_stride[YId] = y_stride_i;

  // Read data valid one cycle after a load grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= ch_gnt[YId:XId];
    end
  end

  // X, W and Y loads
  for (genvar i = XId; i <= YId; i++) begin : gen_load
    assign ch_we[i]    = 1'b0;
    assign ch_wdata[i] = '0;

    load_channel #(
      .AddrW    ( AddrW        )
    ) i_load_channel (
      .clk_i    ( clk_i        ),
      .rst_n_i  ( rst_n_i      ),
      .start_i  ( job_start    ),
      .base_i   ( ld_base[i]   ),
      .stride_i ( ld_stride[i] ),
      .len_i    ( len_i        ),
      .fmt_i    ( fmt_in_i     ),
      .gnt_i    ( ch_gnt[i]    ),
      .rvalid_i ( rvalid_q[i]  ),
      .rdata_i  ( mem_rdata    ),
      .ready_i  ( ld_ready[i]  ),
      .req_o    ( ch_req[i]    ),
      .addr_o   ( ch_addr[i]   ),
      .data_o   ( ld_data[i]   ),
      .valid_o  ( ld_valid[i]  )
    );
  end

  mac_engine i_mac_engine (
    .clk_i     ( clk_i         ),
    .rst_n_i   ( rst_n_i       ),
    .x_i       ( ld_data[XId]  ),
    .x_valid_i ( ld_valid[XId] ),
    .w_i       ( ld_data[WId]  ),
    .w_valid_i ( ld_valid[WId] ),
    .y_i       ( ld_data[YId]  ),
    .y_valid_i ( ld_valid[YId] ),
    .z_ready_i ( z_ready       ),
    .x_ready_o ( ld_ready[XId] ),
    .w_ready_o ( ld_ready[WId] ),
    .y_ready_o ( ld_ready[YId] ),
    .z_o       ( z_data        ),
    .z_valid_o ( z_valid       )
  );

  // Z store is the only writer
  assign ch_we[ZId] = 1'b1;

  store_channel #(
    .AddrW    ( AddrW          )
  ) i_store_channel (
    .clk_i    ( clk_i          ),
    .rst_n_i  ( rst_n_i        ),
    .start_i  ( job_start      ),
    .base_i   ( z_base_i       ),
    .stride_i ( z_stride_i     ),
    .len_i    ( len_i          ),
    .fmt_i    ( fmt_out_i      ),
    .data_i   ( z_data         ),
    .valid_i  ( z_valid        ),
    .gnt_i    ( ch_gnt[ZId]    ),
    .ready_o  ( z_ready        ),
    .req_o    ( ch_req[ZId]    ),
    .addr_o   ( ch_addr[ZId]   ),
    .wdata_o  ( ch_wdata[ZId]  ),
    .done_o   ( st_done        )
  );

  mem_arbiter #(
    .AddrW       ( AddrW     )
  ) i_mem_arbiter (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .req_i       ( ch_req    ),
    .addr_i      ( ch_addr   ),
    .we_i        ( ch_we     ),
    .wdata_i     ( ch_wdata  ),
    .gnt_o       ( ch_gnt    ),
    .mem_en_o    ( arb_en    ),
    .mem_we_o    ( arb_we    ),
    .mem_addr_o  ( arb_addr  ),
    .mem_wdata_o ( arb_wdata )
  );

  // Host owns the memory while idle
  assign mem_en    = busy_q ? arb_en    : 1'b1;
  assign mem_we    = busy_q ? arb_we    : host_we_i;
  assign mem_addr  = busy_q ? arb_addr  : host_addr_i;
  assign mem_wdata = busy_q ? arb_wdata : host_wdata_i;

  scratch_mem #(
    .AddrW   ( AddrW     )
  ) i_scratch_mem (
    .clk_i   ( clk_i     ),
    .en_i    ( mem_en    ),
    .we_i    ( mem_we    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

  assign host_rdata_o = mem_rdata;
  assign busy_o       = busy_q;
  assign done_o       = st_done;

  // Unit goes idle right after the final store
  a_idle_after_done : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !busy_o);

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
`default_nettype none

module clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset held over the first rising edges
  // Released on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/streamer_checker.sv
`default_nettype none

module streamer_checker
  import streamer_cfg_pkg::*;
  import streamer_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      start_i,
  input  addr_t     x_base_i,
  input  addr_t     x_stride_i,
  input  addr_t     w_base_i,
  input  addr_t     w_stride_i,
  input  addr_t     y_base_i,
  input  addr_t     y_stride_i,
  input  addr_t     z_base_i,
  input  addr_t     z_stride_i,
  input  len_t      len_i,
  input  cast_fmt_e fmt_in_i,
  input  cast_fmt_e fmt_out_i,
  input  logic      host_we_i,
  input  addr_t     host_addr_i,
  input  word_t     host_wdata_i,
  input  word_t     host_rdata_i,
  input  logic      check_i,
  input  logic      busy_i,
  input  logic      done_i,
  output int        err_cnt_o,
  output int        chk_cnt_o,
  output int        done_cnt_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Reference image of the scratchpad
  word_t mirror [2 ** MemAddrW];
  // Host read in flight until the next cycle's compare
  logic  rd_pend   = 1'b0;
  addr_t rd_addr   = '0;
  logic  job_open  = 1'b0;
  logic  done_prev = 1'b0;
  int    err_cnt   = 0;
  int    chk_cnt   = 0;
  int    done_cnt  = 0;

  // fp16 in the low half to fp32 with bias 15 to 127
  function automatic word_t widen(input word_t h);
    logic [7:0] e8;
    e8 = 8'(int'(h[14:10]) + 112);
    if (h[14:0] == 15'd0) return word_t'(h[15]) << 31;
    return (word_t'(h[15]) << 31) | (word_t'(e8) << 23) | (word_t'(h[9:0]) << 13);
  endfunction

  // fp32 back to fp16 with the upper half cleared
  function automatic word_t narrow(input word_t f);
    logic [4:0] e5;
    e5 = 5'(int'(f[30:23]) - 112);
    if (f[30:0] == 31'd0) return word_t'(f[31]) << 15;
    return (word_t'(f[31]) << 15) | (word_t'(e5) << 10) | word_t'(f[22:13]);
  endfunction

  // Strided element address wrapping with the address width
  function automatic addr_t elem_addr(input addr_t base, input addr_t stride, input int k);
    return addr_t'(int'(base) + k * int'(stride));
  endfunction

  // Whole job applied to the image at start
  // Regions never overlap so element order does not matter
  task automatic predict_job();
    word_t x;
    word_t w;
    word_t y;
    word_t z;
    int    k;
    for (k = 0; k < int'(len_i); k++) begin
      x = mirror[elem_addr(x_base_i, x_stride_i, k)];
      w = mirror[elem_addr(w_base_i, w_stride_i, k)];
      y = mirror[elem_addr(y_base_i, y_stride_i, k)];
      if (fmt_in_i == FMT_FP16) begin
        x = widen(x);
        w = widen(w);
        y = widen(y);
      end
      // Product and sum of raw bit patterns kept to 32 bits
      z = x * w + y;
      if (fmt_out_i == FMT_FP16) begin
        z = narrow(z);
      end
      mirror[elem_addr(z_base_i, z_stride_i, k)] = z;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      // Data of last cycle's host read is on the port now
      if (rd_pend) begin
        chk_cnt++;
        if (host_rdata_i !== mirror[rd_addr]) begin
          err_cnt++;
          $display("[FAIL] z at 0x%03h: expected 0x%08h, got 0x%08h",
                   rd_addr, mirror[rd_addr], host_rdata_i);
        end
      end
      rd_pend = 1'b0;
      // Unit stays busy from the cycle after start until done
      if (job_open && !busy_i) begin
        err_cnt++;
        $display("busy_o low while a job is running");
      end
      // Host port only reaches the memory while idle
      if (!busy_i) begin
        if (host_we_i) begin
          mirror[host_addr_i] = host_wdata_i;
        end else if (check_i) begin
          rd_pend = 1'b1;
          rd_addr = host_addr_i;
        end
      end
      if (start_i && !busy_i) begin
        predict_job();
        job_open = 1'b1;
      end
      if (done_prev && busy_i) begin
        err_cnt++;
        $display("busy_o still high one cycle after done_o");
      end
      // One done per job
      if (done_i) begin
        done_cnt++;
        if (!job_open) begin
          err_cnt++;
          $display("done_o pulsed with no job running");
        end
        job_open = 1'b0;
      end
      done_prev = done_i;
    end
  end

  assign err_cnt_o  = err_cnt;
  assign chk_cnt_o  = chk_cnt;
  assign done_cnt_o = done_cnt;

endmodule

`default_nettype wire

// File: verification/streamer_tb.sv
`default_nettype none

module streamer_tb
  import streamer_cfg_pkg::*;
  import streamer_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumTests = 7;
  // Data kinds for the X, W and Y regions
  localparam int KindRand = 0;
  localparam int KindHalf = 1;
  localparam int KindZero = 2;

  typedef struct packed {
    addr_t     x_base;
    addr_t     x_stride;
    addr_t     w_base;
    addr_t     w_stride;
    addr_t     y_base;
    addr_t     y_stride;
    addr_t     z_base;
    addr_t     z_stride;
    len_t      len;
    cast_fmt_e fmt_in;
    cast_fmt_e fmt_out;
    int        kind;
  } job_t;

  logic      clk;
  logic      rst_n;
  logic      start;
  addr_t     x_base;
  addr_t     x_stride;
  addr_t     w_base;
  addr_t     w_stride;
  addr_t     y_base;
  addr_t     y_stride;
  addr_t     z_base;
  addr_t     z_stride;
  len_t      len;
  cast_fmt_e fmt_in;
  cast_fmt_e fmt_out;
  logic      host_we;
  addr_t     host_addr;
  word_t     host_wdata;
  word_t     host_rdata;
  logic      check;
  logic      busy;
  logic      done;
  int        err_cnt;
  int        chk_cnt;
  int        done_cnt;

  job_t  jobs [NumTests];
  string names [NumTests];
  int    seed   = 14;
  int    cycles = 0;
  int    limit  = 200;

  clk_gen #(
    .PeriodNs    ( 40 ),
    .ResetCycles ( 5  )
  ) i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  streamer_top #(
    .AddrW        ( MemAddrW   )
  ) i_streamer_top (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .start_i      ( start      ),
    .x_base_i     ( x_base     ),
    .x_stride_i   ( x_stride   ),
    .w_base_i     ( w_base     ),
    .w_stride_i   ( w_stride   ),
    .y_base_i     ( y_base     ),
    .y_stride_i   ( y_stride   ),
    .z_base_i     ( z_base     ),
    .z_stride_i   ( z_stride   ),
    .len_i        ( len        ),
    .fmt_in_i     ( fmt_in     ),
    .fmt_out_i    ( fmt_out    ),
    .host_we_i    ( host_we    ),
    .host_addr_i  ( host_addr  ),
    .host_wdata_i ( host_wdata ),
    .host_rdata_o ( host_rdata ),
    .busy_o       ( busy       ),
    .done_o       ( done       )
  );

  streamer_checker i_streamer_checker (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .start_i      ( start      ),
    .x_base_i     ( x_base     ),
    .x_stride_i   ( x_stride   ),
    .w_base_i     ( w_base     ),
    .w_stride_i   ( w_stride   ),
    .y_base_i     ( y_base     ),
    .y_stride_i   ( y_stride   ),
    .z_base_i     ( z_base     ),
    .z_stride_i   ( z_stride   ),
    .len_i        ( len        ),
    .fmt_in_i     ( fmt_in     ),
    .fmt_out_i    ( fmt_out    ),
    .host_we_i    ( host_we    ),
    .host_addr_i  ( host_addr  ),
    .host_wdata_i ( host_wdata ),
    .host_rdata_i ( host_rdata ),
    .check_i      ( check      ),
    .busy_i       ( busy       ),
    .done_i       ( done       ),
    .err_cnt_o    ( err_cnt    ),
    .chk_cnt_o    ( chk_cnt    ),
    .done_cnt_o   ( done_cnt   )
  );

  task automatic add_job(input int idx, input string name,
                         input int xb, input int xs, input int wb, input int ws,
                         input int yb, input int ys, input int zb, input int zs,
                         input int n, input cast_fmt_e fi, input cast_fmt_e fo,
                         input int kind);
    jobs[idx].x_base   = addr_t'(xb);
    jobs[idx].x_stride = addr_t'(xs);
    jobs[idx].w_base   = addr_t'(wb);
    jobs[idx].w_stride = addr_t'(ws);
    jobs[idx].y_base   = addr_t'(yb);
    jobs[idx].y_stride = addr_t'(ys);
    jobs[idx].z_base   = addr_t'(zb);
    jobs[idx].z_stride = addr_t'(zs);
    jobs[idx].len      = len_t'(n);
    jobs[idx].fmt_in   = fi;
    jobs[idx].fmt_out  = fo;
    jobs[idx].kind     = kind;
    names[idx]         = name;
  endtask

  // Regions of one job never overlap
  task automatic fill_table();
    add_job(0, "fp32 unit stride", 0, 1, 16, 1, 32, 1, 48, 1, 8,
            FMT_FP32, FMT_FP32, KindRand);
    add_job(1, "strided bases", 100, 3, 140, 2, 180, 5, 240, 3, 8,
            FMT_FP32, FMT_FP32, KindRand);
    add_job(2, "fp16 round trip", 300, 1, 320, 1, 340, 1, 360, 1, 8,
            FMT_FP16, FMT_FP16, KindHalf);
    // Back-to-back pair from shortest to longest
    add_job(3, "len 1", 400, 1, 404, 1, 408, 1, 412, 1, 1,
            FMT_FP32, FMT_FP32, KindRand);
    add_job(4, "len 255", 0, 1, 256, 1, 512, 1, 768, 1, 255,
            FMT_FP32, FMT_FP32, KindRand);
    add_job(5, "zero inputs", 430, 1, 440, 1, 450, 1, 460, 1, 4,
            FMT_FP16, FMT_FP16, KindZero);
    // Widened zero seen directly on an fp32 result
    add_job(6, "zero widen", 470, 1, 480, 1, 490, 1, 500, 1, 4,
            FMT_FP16, FMT_FP32, KindZero);
  endtask

  // Small normal fp16 has exponent 13 to 16
  function automatic word_t gen_word(input int kind);
    word_t      r;
    logic [4:0] e;
    r = $random(seed);
    e = 5'd13 + {3'b000, r[12:11]};
    if (kind == KindZero) return '0;
    if (kind == KindHalf) return {16'h0000, r[15], e, r[9:0]};
    return r;
  endfunction

  function automatic int span_of(input addr_t stride, input len_t n);
    return (int'(n) - 1) * int'(stride) + 1;
  endfunction

  // Fill every word from the first to the last element
  task automatic preload_span(input addr_t base, input addr_t stride, input len_t n,
                              input int kind);
    int k;
    for (k = 0; k < span_of(stride, n); k++) begin
      @(negedge clk);
      host_we    = 1'b1;
      host_addr  = addr_t'(int'(base) + k);
      host_wdata = gen_word(kind);
    end
    @(negedge clk);
    host_we = 1'b0;
  endtask

  task automatic run_job(input job_t j);
    @(negedge clk);
    x_base   = j.x_base;
    x_stride = j.x_stride;
    w_base   = j.w_base;
    w_stride = j.w_stride;
    y_base   = j.y_base;
    y_stride = j.y_stride;
    z_base   = j.z_base;
    z_stride = j.z_stride;
    len      = j.len;
    fmt_in   = j.fmt_in;
    fmt_out  = j.fmt_out;
    start    = 1'b1;
    @(negedge clk);
    start = 1'b0;
    // Latency depends on arbitration
    while (!done) @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  // Whole Z span including the gaps
  task automatic read_back(input job_t j);
    int k;
    for (k = 0; k < span_of(j.z_stride, j.len); k++) begin
      @(negedge clk);
      host_we   = 1'b0;
      host_addr = addr_t'(int'(j.z_base) + k);
      check     = 1'b1;
    end
    @(negedge clk);
    check = 1'b0;
    // Last compare lands on the next rising edge
    @(negedge clk);
  endtask

  initial begin
    int t;
    int errs_before;
    int failed_tests;
    logic done_ok;
    start      = 1'b0;
    x_base     = '0;
    x_stride   = '0;
    w_base     = '0;
    w_stride   = '0;
    y_base     = '0;
    y_stride   = '0;
    z_base     = '0;
    z_stride   = '0;
    len        = '0;
    fmt_in     = FMT_FP32;
    fmt_out    = FMT_FP32;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    check      = 1'b0;
    failed_tests = 0;
    fill_table();
    for (t = 0; t < NumTests; t++) begin
      limit += 20 * int'(jobs[t].len);
    end
    wait (rst_n == 1'b1);
    for (t = 0; t < NumTests; t++) begin
      errs_before = err_cnt;
      preload_span(jobs[t].x_base, jobs[t].x_stride, jobs[t].len, jobs[t].kind);
      preload_span(jobs[t].w_base, jobs[t].w_stride, jobs[t].len, jobs[t].kind);
      preload_span(jobs[t].y_base, jobs[t].y_stride, jobs[t].len, jobs[t].kind);
      // Z span gets random words so untouched gaps are visible
      preload_span(jobs[t].z_base, jobs[t].z_stride, jobs[t].len, KindRand);
      run_job(jobs[t]);
      read_back(jobs[t]);
      if (err_cnt == errs_before) begin
        $display("test %0d %s: passed", t + 1, names[t]);
      end else begin
        failed_tests++;
        $display("test %0d %s: %0d errors", t + 1, names[t], err_cnt - errs_before);
      end
    end
    done_ok = (done_cnt == NumTests);
    if (!done_ok) begin
      $display("done_o pulsed %0d times over %0d jobs", done_cnt, NumTests);
    end
    $display("%0d of %0d tests clean, %0d words checked, %0d errors",
             NumTests - failed_tests, NumTests, chk_cnt, err_cnt);
    if (failed_tests == 0 && err_cnt == 0 && done_ok && chk_cnt > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Cycle budget from the job lengths
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout, run still going after %0d cycles", limit);
      $display("tests failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
design/streamer_cfg_pkg.sv
design/streamer_ctrl_pkg.sv
design/mem_arbiter.sv
design/scratch_mem.sv
design/load_channel.sv
design/store_channel.sv
design/mac_engine.sv
design/streamer_top.sv
verification/clk_gen.sv
verification/streamer_checker.sv
verification/streamer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the streamer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module streamer_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/Vstreamer_tb)"
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
